//--- rbk_regfile.f
+incdir+source
source/rbk_regfile_pkg.sv
source/rbk_csb_decode.sv
source/rbk_dual_group.sv
source/rbk_group_ctrl.sv
source/rbk_csb_resp.sv
source/rbk_regfile.sv
tb/tb_rbk_regfile.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the rubik register file testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_rbk_regfile
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module "$top" \
  --Mdir "$build_dir" \
  -f rbk_regfile.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  echo "pass message found in $log"
  exit 0
fi

echo "pass message not found in $log"
exit 1

//--- tb/tb_rbk_regfile.sv
////////////////////////////////////////////////////////////
// rubik register file testbench
// csb stimulus checked against a shadow model of the register
// rules plus response and op_en timing checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rbk_regfile_consts.svh"

module tb_rbk_regfile
  import rbk_regfile_pkg::*;
();

  // about 50 bus accesses of up to 7 cycles each plus margin
  localparam int MAX_CYCLES = 4000;

  logic        autosa_core_clk = 1'b0;
  logic        autosa_core_rstn;
  logic        csb_req_pvld;
  csb_req_t    csb_req_pd;
  logic        dp_done;
  logic        csb_resp_valid;
  csb_resp_t   csb_resp_pd;
  logic        op_en;
  rbk_cfg_t    cfg;
  logic        consumer;

  // shadow model
  logic        mdl_prod;
  logic        mdl_cons;
  logic [1:0]  mdl_en;        // per group enable
  logic        mdl_sel;       // enable of the consumer's group
  logic [31:0] mdl_reg [2][8];  // expected read word by offset/4

  integer      seed;
  int          cycle_cnt = 0;
  int          test_errors;
  int          resp_sva_errors = 0;
  int          op_en_sva_errors = 0;
  int          sva_base;
  int          total_errors;
  int          tests_run;
  int          tests_clean;

  always #4 autosa_core_clk = ~autosa_core_clk;  // 8 ns period

  rbk_regfile rbk_regfile_i (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .csb_req_pvld     (csb_req_pvld),
    .csb_req_pd       (csb_req_pd),
    .dp_done          (dp_done),
    .csb_resp_valid   (csb_resp_valid),
    .csb_resp_pd      (csb_resp_pd),
    .op_en            (op_en),
    .cfg              (cfg),
    .consumer         (consumer)
  );

  ////////////////////////////////////////////////////////////
  // timing checks
  ////////////////////////////////////////////////////////////
  assign mdl_sel = mdl_en[mdl_cons];

  // response 2 edges after a sampled request that needs one
  resp_timing: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
      csb_resp_valid == $past(csb_req_pvld && (!csb_req_pd.write || csb_req_pd.nposted), 2))
    else begin
      $display("** Error: %0t: csb_resp_valid off the 2 cycle response timing", $time);
      resp_sva_errors++;
    end

  // 3 stage chain that any done in flight flushes
  op_en_delay: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
      op_en == ($past(mdl_sel, 3) && !$past(dp_done, 1) && !$past(dp_done, 2)
                && !$past(dp_done, 3)))
    else begin
      $display("** Error: %0t: op_en %0b off the 3 cycle enable delay", $time, op_en);
      op_en_sva_errors++;
    end

  always @(posedge autosa_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // model
  ////////////////////////////////////////////////////////////
  // writable bits per field register
  function automatic logic [31:0] field_mask(input logic [11:0] ofs);
    case (ofs)
      `RBK_OFS_MISC_CFG:      return 32'h0000_0303;
      `RBK_OFS_DATAIN_SIZE_0: return 32'h1fff_1fff;
      `RBK_OFS_DATAIN_SIZE_1: return 32'h0000_1fff;
      `RBK_OFS_DAIN_ADDR_LOW: return 32'h07ff_ffff;
      default:                return 32'h0;
    endcase
  endfunction

  function automatic logic [1:0] group_status(input logic g);
    if (!mdl_en[g]) begin
      return `RBK_ST_IDLE;
    end
    return (mdl_cons == g) ? `RBK_ST_RUNNING : `RBK_ST_PENDING;
  endfunction

  function automatic logic [31:0] expected_read(input logic [11:0] ofs);
    logic [31:0] word;
    word = 32'h0;
    if (ofs == `RBK_OFS_POINTER) begin
      word[0]  = mdl_prod;
      word[16] = mdl_cons;
    end else if (ofs == `RBK_OFS_STATUS) begin
      word[1:0]   = group_status(1'b0);
      word[17:16] = group_status(1'b1);
    end else if (field_mask(ofs) != 32'h0) begin
      word = mdl_reg[mdl_prod][ofs[4:2]];  // producer picks the group
    end
    return word;
  endfunction

  function automatic rbk_cfg_t expected_cfg();
    rbk_cfg_t c;
    logic     g;
    g               = mdl_cons;
    c.mode          = rubik_mode_e'(mdl_reg[g][3][1:0]);
    c.precision     = precision_e'(mdl_reg[g][3][9:8]);
    c.width         = mdl_reg[g][4][12:0];
    c.height        = mdl_reg[g][4][28:16];
    c.channel       = mdl_reg[g][5][12:0];
    c.dain_addr_low = mdl_reg[g][6][26:0];
    return c;
  endfunction

  // applied on the edge where the dut write lands
  task automatic model_write(input logic [11:0] ofs, input logic [31:0] wdat);
    logic g;
    g = mdl_prod;
    if (ofs == `RBK_OFS_POINTER) begin
      mdl_prod <= wdat[0];
    end else if (ofs >= `RBK_OFS_GROUP_BASE && !mdl_en[g]) begin  // enabled group is locked
      if (ofs == `RBK_OFS_OP_ENABLE) begin
        mdl_en[g] <= wdat[0];
      end else if (field_mask(ofs) != 32'h0) begin
        mdl_reg[g][ofs[4:2]] <= wdat & field_mask(ofs);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and datapath drivers
  ////////////////////////////////////////////////////////////
  task automatic release_reset();
    repeat (5) @(posedge autosa_core_clk);
    autosa_core_rstn <= 1'b1;
    @(negedge autosa_core_clk);
  endtask

  task automatic bus_xfer(input logic wr, input logic np, input logic [11:0] ofs,
                          input logic [31:0] wdat, output logic got, output csb_resp_t resp);
    csb_req_t req;
    int       waited;
    req         = '0;
    req.addr    = {12'd0, ofs[11:2]};  // word address
    req.wdat    = wdat;
    req.write   = wr;
    req.nposted = np;
    req.wrbe    = 4'hf;
    @(posedge autosa_core_clk);
    csb_req_pvld <= 1'b1;
    csb_req_pd   <= req;
    @(posedge autosa_core_clk);  // request sampled here
    csb_req_pvld <= 1'b0;
    @(posedge autosa_core_clk);
    if (wr) begin
      model_write(ofs, wdat);
    end
    got    = 1'b0;
    resp   = '0;
    waited = 0;
    while (!got && waited < 4) begin
      @(negedge autosa_core_clk);
      if (csb_resp_valid) begin
        got  = 1'b1;
        resp = csb_resp_pd;
      end
      waited++;
    end
  endtask

  task automatic pulse_done();
    @(posedge autosa_core_clk);
    dp_done <= 1'b1;
    @(posedge autosa_core_clk);
    dp_done  <= 1'b0;
    mdl_en[mdl_cons] <= 1'b0;  // retire consumer's group
    mdl_cons <= ~mdl_cons;
    @(negedge autosa_core_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  task automatic check_read(input logic [11:0] ofs);
    logic        got;
    csb_resp_t   resp;
    logic [31:0] exp_data;
    exp_data = expected_read(ofs);
    bus_xfer(1'b0, 1'b0, ofs, 32'h0, got, resp);
    if (!got) begin
      $display("no response to the read of offset 0x%03h at %0t", ofs, $time);
      test_errors++;
    end else begin
      assert (resp.kind == RESP_READ && !resp.error && resp.rdat == exp_data)
      else begin
        $display("** Error: %0t: read 0x%03h gave kind %0d data 0x%08h, expected 0x%08h",
                 $time, ofs, resp.kind, resp.rdat, exp_data);
        test_errors++;
      end
    end
  endtask

  task automatic check_write(input logic [11:0] ofs, input logic [31:0] wdat,
                             input logic np);
    logic      got;
    csb_resp_t resp;
    bus_xfer(1'b1, np, ofs, wdat, got, resp);
    if (got != np) begin
      $display("write to offset 0x%03h (non-posted %0b) %s a response at %0t",
               ofs, np, got ? "got" : "missed", $time);
      test_errors++;
    end else if (np) begin
      assert (resp.kind == RESP_WRITE && !resp.error && resp.rdat == 32'h0)
      else begin
        $display("** Error: %0t: write ack for 0x%03h has kind %0d data 0x%08h",
                 $time, ofs, resp.kind, resp.rdat);
        test_errors++;
      end
    end
  endtask

  task automatic check_bit(input string what, input logic act, input logic exp);
    assert (act === exp)
    else begin
      $display("** Error: %0t: %s is %0b, expected %0b", $time, what, act, exp);
      test_errors++;
    end
  endtask

  task automatic check_cfg();
    rbk_cfg_t exp_cfg;
    exp_cfg = expected_cfg();
    assert (cfg === exp_cfg)
    else begin
      $display("** Error: %0t: cfg 0x%018h, expected 0x%018h", $time, cfg, exp_cfg);
      test_errors++;
    end
  endtask

  task automatic check_op_en_rise();
    int n;
    n = 0;
    while (!op_en && n < 8) begin  // bounded wait for the rise
      @(posedge autosa_core_clk);
      @(negedge autosa_core_clk);
      n++;
    end
    assert (n == `RBK_OP_EN_DEPTH)
    else begin
      $display("** Error: %0t: op_en rose after %0d cycles, expected %0d",
               $time, n, `RBK_OP_EN_DEPTH);
      test_errors++;
    end
  endtask

  task automatic write_random_fields();
    logic [11:0] ofs;
    ofs = `RBK_OFS_MISC_CFG;
    repeat (4) begin
      check_write(ofs, $random(seed), 1'b1);
      ofs = ofs + 12'h4;
    end
  endtask

  task automatic read_fields();
    logic [11:0] ofs;
    ofs = `RBK_OFS_MISC_CFG;
    repeat (4) begin
      check_read(ofs);
      ofs = ofs + 12'h4;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs     = test_errors + resp_sva_errors + op_en_sva_errors - sva_base;
    sva_base = resp_sva_errors + op_en_sva_errors;
    tests_run++;
    if (errs == 0) begin
      tests_clean++;
      $display("[%0d] %s: ok", tests_run, name);
    end else begin
      $display("[%0d] %s: %0d errors", tests_run, name, errs);
    end
    total_errors += errs;
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [11:0] ofs;
    seed             = 10;
    autosa_core_rstn = 1'b0;
    csb_req_pvld     = 1'b0;
    csb_req_pd       = '0;
    dp_done          = 1'b0;
    mdl_prod         = 1'b0;
    mdl_cons         = 1'b0;
    mdl_en           = 2'b00;
    for (int g = 0; g < 2; g++) begin
      for (int i = 0; i < 8; i++) begin
        mdl_reg[g][i] = 32'h0;
      end
    end
    test_errors  = 0;
    sva_base     = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_clean  = 0;
    release_reset();

    // every defined offset reads zero before the two write kinds
    check_bit("op_en", op_en, 1'b0);
    check_bit("consumer", consumer, 1'b0);
    check_cfg();
    ofs = `RBK_OFS_POINTER;
    repeat (7) begin
      check_read(ofs);
      ofs = ofs + 12'h4;
    end
    check_write(`RBK_OFS_POINTER, 32'h0, 1'b0);  // posted, no ack
    check_write(`RBK_OFS_POINTER, 32'h0, 1'b1);
    end_test("reset state and response kinds");

    // producer and consumer both 0
    write_random_fields();
    read_fields();
    check_cfg();
    end_test("group 0 configuration");

    check_write(`RBK_OFS_OP_ENABLE, 32'h1, 1'b1);
    check_op_en_rise();
    check_read(`RBK_OFS_STATUS);     // group 0 running
    check_read(`RBK_OFS_OP_ENABLE);  // reads zero
    write_random_fields();           // dropped while group 0 is locked
    read_fields();
    check_cfg();
    end_test("write protection");

    check_write(`RBK_OFS_POINTER, 32'h1, 1'b1);
    write_random_fields();
    read_fields();
    check_write(`RBK_OFS_OP_ENABLE, 32'h1, 1'b1);
    check_read(`RBK_OFS_STATUS);  // running / pending
    check_bit("op_en", op_en, 1'b1);
    pulse_done();
    check_bit("op_en", op_en, 1'b0);
    check_bit("consumer", consumer, 1'b1);
    check_cfg();                  // now group 1
    check_op_en_rise();
    check_read(`RBK_OFS_STATUS);  // idle / running
    end_test("ping-pong");

    check_read(`RBK_OFS_POINTER);                // both pointers at 1
    check_write(`RBK_OFS_POINTER, 32'h0, 1'b1);
    check_read(`RBK_OFS_POINTER);                // producer 0 against consumer 1
    check_read(12'h01c);
    check_read(12'h020);
    check_read(12'h400);
    check_read(12'hffc);
    end_test("pointer read-back");

    $display("tests %0d, clean %0d, errors %0d", tests_run, tests_clean, total_errors);
    if (total_errors == 0 && tests_clean == tests_run) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/rbk_regfile.sv
////////////////////////////////////////////////////////////
// rubik register file top
// csb decode, two ping-pong config groups, group control
// and response builder
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rbk_regfile_consts.svh"

module rbk_regfile
  import rbk_regfile_pkg::*;
(
  input  wire       autosa_core_clk,
  input  wire       autosa_core_rstn,
  input  wire       csb_req_pvld,
  input  csb_req_t  csb_req_pd,
  input  wire       dp_done,
  output logic      csb_resp_valid,
  output csb_resp_t csb_resp_pd,
  output logic      op_en,
  output rbk_cfg_t  cfg,
  output logic      consumer
);

  reg_access_t            access;
  logic                   g0_wr_en;
  logic                   g1_wr_en;
  logic [`RBK_DATA_W-1:0] g0_rd_data;
  logic [`RBK_DATA_W-1:0] g1_rd_data;
  rbk_cfg_t               g0_cfg;
  rbk_cfg_t               g1_cfg;
  logic                   g0_trigger;
  logic                   g1_trigger;
  logic [`RBK_DATA_W-1:0] rd_data;  // selected read word

  rbk_csb_decode u_decode (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .csb_req_pvld     (csb_req_pvld),
    .csb_req_pd       (csb_req_pd),
    .access           (access)
  );

  ////////////////////////////////////////////////////////////
  // ping-pong groups
  ////////////////////////////////////////////////////////////
  rbk_dual_group u_group_0 (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .wr_en            (g0_wr_en),
    .offset           (access.offset),
    .wr_data          (access.wr_data),
    .rd_data          (g0_rd_data),
    .cfg              (g0_cfg),
    .op_en_trigger    (g0_trigger)
  );

  rbk_dual_group u_group_1 (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .wr_en            (g1_wr_en),
    .offset           (access.offset),
    .wr_data          (access.wr_data),
    .rd_data          (g1_rd_data),
    .cfg              (g1_cfg),
    .op_en_trigger    (g1_trigger)
  );

  rbk_group_ctrl u_ctrl (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .access           (access),
    .dp_done          (dp_done),
    .g0_rd_data       (g0_rd_data),
    .g1_rd_data       (g1_rd_data),
    .g0_cfg           (g0_cfg),
    .g1_cfg           (g1_cfg),
    .g0_trigger       (g0_trigger),
    .g1_trigger       (g1_trigger),
    .g0_wr_en         (g0_wr_en),
    .g1_wr_en         (g1_wr_en),
    .rd_data          (rd_data),
    .cfg              (cfg),
    .op_en            (op_en),
    .consumer         (consumer)
  );

  rbk_csb_resp u_resp (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .access           (access),
    .rd_data          (rd_data),
    .csb_resp_valid   (csb_resp_valid),
    .csb_resp_pd      (csb_resp_pd)
  );

endmodule

`default_nettype wire

//--- source/rbk_csb_resp.sv
////////////////////////////////////////////////////////////
// rubik csb response
// read responses and non-posted write acks, one cycle after
// the register access
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rbk_regfile_consts.svh"

module rbk_csb_resp
  import rbk_regfile_pkg::*;
(
  input  wire                   autosa_core_clk,
  input  wire                   autosa_core_rstn,
  input  reg_access_t           access,
  input  wire [`RBK_DATA_W-1:0] rd_data,
  output logic                  csb_resp_valid,
  output csb_resp_t             csb_resp_pd
);

  logic      resp_needed;
  csb_resp_t resp_w;

  // posted writes get no ack
  assign resp_needed = access.rd_en | (access.wr_en & access.nposted);

  always_comb begin
    resp_w.kind  = access.rd_en ? RESP_READ : RESP_WRITE;
    resp_w.error = 1'b0;  // no error path
    resp_w.rdat  = access.rd_en ? rd_data : '0;
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= resp_needed;
    end
  end

  always_ff @(posedge autosa_core_clk) begin
    if (resp_needed) begin
      csb_resp_pd <= resp_w;  // held between responses
    end
  end

endmodule

`default_nettype wire

//--- source/rbk_group_ctrl.sv
////////////////////////////////////////////////////////////
// rubik group control
// producer / consumer pointers, per-group op enables, status,
// write protection, read mux and config mux to the datapath
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rbk_regfile_consts.svh"

module rbk_group_ctrl
  import rbk_regfile_pkg::*;
(
  input  wire                    autosa_core_clk,
  input  wire                    autosa_core_rstn,
  input  reg_access_t            access,
  input  wire                    dp_done,      // one cycle pulse from datapath
  input  wire [`RBK_DATA_W-1:0]  g0_rd_data,
  input  wire [`RBK_DATA_W-1:0]  g1_rd_data,
  input  rbk_cfg_t               g0_cfg,
  input  rbk_cfg_t               g1_cfg,
  input  wire                    g0_trigger,
  input  wire                    g1_trigger,
  output logic                   g0_wr_en,
  output logic                   g1_wr_en,
  output logic [`RBK_DATA_W-1:0] rd_data,
  output rbk_cfg_t               cfg,
  output logic                   op_en,
  output logic                   consumer
);

  logic                        producer;   // sw side pointer
  logic                        g0_en;
  logic                        g1_en;
  logic                        op_en_sel;  // enable of consumer's group
  logic [`RBK_OP_EN_DEPTH-1:0] op_en_pipe;
  logic                        select_s;
  logic                        select_d0;
  logic                        select_d1;
  logic [`RBK_DATA_W-1:0]      s_rd_data;
  group_status_e               status_0;
  group_status_e               status_1;

  ////////////////////////////////////////////////////////////
  // address select and write protection
  ////////////////////////////////////////////////////////////
  assign select_s  = access.offset < `RBK_OFS_GROUP_BASE;
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;

  assign g0_wr_en = access.wr_en & select_d0 & ~g0_en;  // locked while enabled
  assign g1_wr_en = access.wr_en & select_d1 & ~g1_en;

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
    end else begin
      if (access.wr_en & select_s & (access.offset == `RBK_OFS_POINTER)) begin
        producer <= access.wr_data[0];
      end
      if (dp_done) begin
        consumer <= ~consumer;  // next group takes over
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // op enables, set by sw, cleared by done
  ////////////////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      g0_en <= 1'b0;
      g1_en <= 1'b0;
    end else begin
      if (~g0_en & g0_trigger) begin
        g0_en <= access.wr_data[0];
      end else if (dp_done & ~consumer) begin
        g0_en <= 1'b0;
      end
      if (~g1_en & g1_trigger) begin
        g1_en <= access.wr_data[0];
      end else if (dp_done & consumer) begin
        g1_en <= 1'b0;
      end
    end
  end

  // delay chain toward datapath, flushed on done
  assign op_en_sel = consumer ? g1_en : g0_en;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      op_en_pipe <= '0;
    end else if (dp_done) begin
      op_en_pipe <= '0;
    end else begin
      op_en_pipe <= {op_en_pipe[`RBK_OP_EN_DEPTH-2:0], op_en_sel};
    end
  end

  assign op_en = op_en_pipe[`RBK_OP_EN_DEPTH-1];

  ////////////////////////////////////////////////////////////
  // status and single group read
  ////////////////////////////////////////////////////////////
  assign status_0 = ~g0_en     ? ST_IDLE :
                    ~consumer  ? ST_RUNNING : ST_PENDING;
  assign status_1 = ~g1_en     ? ST_IDLE :
                    consumer   ? ST_RUNNING : ST_PENDING;

  always_comb begin
    s_rd_data = '0;
    case (access.offset)
      `RBK_OFS_POINTER: begin
        s_rd_data[0]  = producer;
        s_rd_data[16] = consumer;
      end
      `RBK_OFS_STATUS: begin
        s_rd_data[1:0]   = status_0;
        s_rd_data[17:16] = status_1;
      end
      default: s_rd_data = '0;
    endcase
  end

  // read mux follows the write selection
  assign rd_data = select_s  ? s_rd_data  :
                   select_d1 ? g1_rd_data : g0_rd_data;

  // datapath sees the consumer's group
  assign cfg = consumer ? g1_cfg : g0_cfg;

endmodule

`default_nettype wire

//--- source/rbk_dual_group.sv
////////////////////////////////////////////////////////////
// rubik duplicated config group
// one ping-pong copy of the config fields, with read-back
// and op enable trigger detect
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rbk_regfile_consts.svh"

module rbk_dual_group
  import rbk_regfile_pkg::*;
(
  input  wire                    autosa_core_clk,
  input  wire                    autosa_core_rstn,
  input  wire                    wr_en,          // already gated by select / protect
  input  wire [`RBK_OFFS_W-1:0]  offset,
  input  wire [`RBK_DATA_W-1:0]  wr_data,
  output logic [`RBK_DATA_W-1:0] rd_data,
  output rbk_cfg_t               cfg,
  output logic                   op_en_trigger   // write to OP_ENABLE seen
);

  rbk_cfg_t cfg_q;  // field storage

  ////////////////////////////////////////////////////////////
  // field writes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (offset)
        `RBK_OFS_MISC_CFG: begin
          cfg_q.mode      <= rubik_mode_e'(wr_data[1:0]);
          cfg_q.precision <= precision_e'(wr_data[9:8]);
        end
        `RBK_OFS_DATAIN_SIZE_0: begin
          cfg_q.width  <= wr_data[`RBK_DIM_W-1:0];
          cfg_q.height <= wr_data[16 +: `RBK_DIM_W];
        end
        `RBK_OFS_DATAIN_SIZE_1: begin
          cfg_q.channel <= wr_data[`RBK_DIM_W-1:0];
        end
        `RBK_OFS_DAIN_ADDR_LOW: begin
          cfg_q.dain_addr_low <= wr_data[`RBK_ADDR_LO_W-1:0];
        end
        default: begin
          // OP_ENABLE lives in group ctrl, rest unmapped
        end
      endcase
    end
  end

  assign cfg = cfg_q;

  // enable itself is held upstream
  assign op_en_trigger = wr_en & (offset == `RBK_OFS_OP_ENABLE);

  ////////////////////////////////////////////////////////////
  // read-back, fields at their write positions
  ////////////////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;  // OP_ENABLE and unmapped read zero
    case (offset)
      `RBK_OFS_MISC_CFG: begin
        rd_data[1:0] = cfg_q.mode;
        rd_data[9:8] = cfg_q.precision;
      end
      `RBK_OFS_DATAIN_SIZE_0: begin
        rd_data[`RBK_DIM_W-1:0]  = cfg_q.width;
        rd_data[16 +: `RBK_DIM_W] = cfg_q.height;
      end
      `RBK_OFS_DATAIN_SIZE_1: rd_data[`RBK_DIM_W-1:0] = cfg_q.channel;
      `RBK_OFS_DAIN_ADDR_LOW: rd_data[`RBK_ADDR_LO_W-1:0] = cfg_q.dain_addr_low;
      default: rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rbk_csb_decode.sv
////////////////////////////////////////////////////////////
// rubik csb request decode
// registers the csb request and turns it into a byte-offset
// register access for the group logic
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rbk_regfile_consts.svh"

module rbk_csb_decode
  import rbk_regfile_pkg::*;
(
  input  wire         autosa_core_clk,
  input  wire         autosa_core_rstn,
  input  wire         csb_req_pvld,    // request strobe, always accepted
  input  csb_req_t    csb_req_pd,
  output reg_access_t access
);

  logic     req_pvld;  // registered strobe
  csb_req_t req_pd;    // registered payload

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_pvld;
    end
  end

  // payload only moves with the strobe
  always_ff @(posedge autosa_core_clk) begin
    if (csb_req_pvld) begin
      req_pd <= csb_req_pd;  // wrbe / srcpriv / level ride along
    end
  end

  ////////////////////////////////////////////////////////////
  // unpack
  ////////////////////////////////////////////////////////////
  always_comb begin
    // csb addr is a word address, regfile works in bytes
    access.offset  = {req_pd.addr[`RBK_OFFS_W-3:0], 2'b00};
    access.wr_data = req_pd.wdat;
    access.wr_en   = req_pvld & req_pd.write;
    access.rd_en   = req_pvld & ~req_pd.write;
    access.nposted = req_pd.nposted;  // write wants an ack
  end

endmodule

`default_nettype wire

//--- source/rbk_regfile_pkg.sv
////////////////////////////////////////////////////////////
// rubik register file types
// csb packets, register access word, config bundle, enums
////////////////////////////////////////////////////////////
`default_nettype none

`include "rbk_regfile_consts.svh"

package rbk_regfile_pkg;

  ////////////////////////////////////////////////////////////
  // csb side
  ////////////////////////////////////////////////////////////
  // request, addr in the low bits
  typedef struct packed {
    logic [1:0]             level;    // unused here
    logic [3:0]             wrbe;     // unused here
    logic                   srcpriv;  // unused here
    logic                   nposted;
    logic                   write;
    logic [`RBK_DATA_W-1:0] wdat;
    logic [`RBK_ADDR_W-1:0] addr;
  } csb_req_t;

  typedef enum logic {
    RESP_READ  = 1'b0,
    RESP_WRITE = 1'b1
  } resp_kind_e;

  // response, kind in the top bit
  typedef struct packed {
    resp_kind_e             kind;
    logic                   error;
    logic [`RBK_DATA_W-1:0] rdat;
  } csb_resp_t;

  // unpacked register access, valid one cycle after the request
  typedef struct packed {
    logic                   nposted;
    logic                   rd_en;
    logic                   wr_en;
    logic [`RBK_DATA_W-1:0] wr_data;
    logic [`RBK_OFFS_W-1:0] offset;   // byte offset
  } reg_access_t;

  ////////////////////////////////////////////////////////////
  // config fields
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    MODE_CONTRACT = 2'd0,
    MODE_SPLIT    = 2'd1,
    MODE_MERGE    = 2'd2
  } rubik_mode_e;

  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,
    PREC_INT16 = 2'd1,
    PREC_FP16  = 2'd2
  } precision_e;

  typedef enum logic [1:0] {
    ST_IDLE    = `RBK_ST_IDLE,
    ST_PENDING = `RBK_ST_PENDING,
    ST_RUNNING = `RBK_ST_RUNNING
  } group_status_e;

  // toward the datapath
  typedef struct packed {
    rubik_mode_e               mode;
    precision_e                precision;
    logic [`RBK_DIM_W-1:0]     width;
    logic [`RBK_DIM_W-1:0]     height;
    logic [`RBK_DIM_W-1:0]     channel;
    logic [`RBK_ADDR_LO_W-1:0] dain_addr_low;
  } rbk_cfg_t;

endpackage

`default_nettype wire

//--- source/rbk_regfile_consts.svh
////////////////////////////////////////////////////////////
// rubik register file constants
// widths, register map offsets, status codes, op_en delay
////////////////////////////////////////////////////////////
`ifndef RBK_REGFILE_CONSTS_SVH
`define RBK_REGFILE_CONSTS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////
`define RBK_DATA_W     32   // register data
`define RBK_ADDR_W     22   // csb word address
`define RBK_OFFS_W     12   // byte offset, 4KB space
`define RBK_DIM_W      13   // width / height / channel
`define RBK_ADDR_LO_W  27   // input base address, low part

////////////////////////////////////////////////////////////
// register map, byte offsets
////////////////////////////////////////////////////////////
// single group
`define RBK_OFS_POINTER        12'h000  // producer bit 0, consumer bit 16 (ro)
`define RBK_OFS_STATUS         12'h004  // status_0 1:0, status_1 17:16
// duplicated groups start here
`define RBK_OFS_GROUP_BASE     12'h008
`define RBK_OFS_OP_ENABLE      12'h008  // op enable bit 0
`define RBK_OFS_MISC_CFG       12'h00C  // mode 1:0, precision 9:8
`define RBK_OFS_DATAIN_SIZE_0  12'h010  // width 12:0, height 28:16
`define RBK_OFS_DATAIN_SIZE_1  12'h014  // channel 12:0
`define RBK_OFS_DAIN_ADDR_LOW  12'h018  // base address 26:0

////////////////////////////////////////////////////////////
// per-group status codes
////////////////////////////////////////////////////////////
`define RBK_ST_IDLE     2'd0
`define RBK_ST_PENDING  2'd1
`define RBK_ST_RUNNING  2'd2

// stages between selected enable and op_en
`define RBK_OP_EN_DEPTH 3

`endif
